// ==== common/hram_pkg.sv ====
package hram_pkg;

	//////////////////////////////
	// Burst request and command/address

	// One burst as the PHY sees it
	typedef struct packed {
		logic			rd;			// 1 = read, 0 = write
		logic			is_reg;		// 1 = register space
		logic			linear;		// 1 = linear, 0 = wrapped
		logic [28:0]	upper_addr;	// Row and upper column
		logic [2:0]		lower_addr;	// Word within the 8-word page
		logic [7:0]		len;		// Burst length in 16-bit words
	} burst_req_t;

	// 48-bit CA, sent as three words, MSW first
	typedef struct packed {
		logic			rd;
		logic			is_reg;
		logic			linear;
		logic [28:0]	upper_addr;
		logic [12:0]	rsvd;		// Always zero
		logic [2:0]		lower_addr;
	} ca_word_t;

	//////////////////////////////
	// Device registers

	// ID register 0, taken as a whole word or split into fields
	typedef union packed {
		logic [15:0]	raw;
		struct packed {
			logic [2:0]	rsvd;
			logic [4:0]	rows_m1;	// Row address bits minus one
			logic [3:0]	cols_m1;	// Column address bits minus one
			logic [3:0]	mfr;		// Manufacturer code
		} fields;
	} id0_u;

	// Configuration register 0
	typedef struct packed {
		logic			normal_op;	// 0 = deep power down
		logic [2:0]		drive;		// Output drive strength
		logic [3:0]		reserved;	// Must be ones
		logic [3:0]		latency;	// Initial latency code
		logic			fixed_lat;	// 1 = always 2x latency
		logic			hybrid;		// 1 = legacy wrapped order
		logic [1:0]		burst_sel;	// Wrap length
	} cfg0_t;

	// Normal op, 46 ohm, latency code 1, fixed latency, legacy wrap, 32 bytes
	localparam cfg0_t CFG0_VALUE = '{
		normal_op:	1'b1,
		drive:		3'b011,
		reserved:	4'b1111,
		latency:	4'b0001,
		fixed_lat:	1'b1,
		hybrid:		1'b1,
		burst_sel:	2'b11
	};

	//////////////////////////////
	// Burst sizes and addresses

	localparam logic [7:0]	BURST_WORDS	= 8'd16;	// 8 host words
	localparam logic [7:0]	REG_WORDS	= 8'd1;
	localparam logic [3:0]	MFR_CYPRESS	= 4'h1;
	localparam logic [28:0]	CFG0_ADDR	= 29'h100;
	localparam logic [28:0]	ID0_ADDR	= 29'h0;

	//////////////////////////////
	// State encodings

	typedef enum logic [3:0] {
		IDLE, CA0, CA1, CA2,
		WRITE_WAIT, WRITE_DATA, WRITE_LAST,
		RWDS_WAIT, PRE_DATA, READ_DATA
	} phy_state_e;

	typedef enum logic [2:0] {
		RST_LOW, RST_WAIT, ID_READ, CFG_WRITE, RUN
	} boot_state_e;

endpackage

// ==== hdl/hram_boot.sv ====
`timescale 1ns/1ns

module hram_boot #(
	parameter int RST_LOW_CYCLES	= 64,
	parameter int RST_WAIT_CYCLES	= 128
) (
	input  logic					clk,
	input  logic					rst_n,
	input  logic					burst_done,
	input  logic [15:0]				rdata,
	input  logic					rdata_valid,
	output logic					ram_rst_n,
	output hram_pkg::burst_req_t	boot_burst,
	output logic					boot_start,
	output logic [15:0]				boot_wdata,
	output logic					status_valid,
	output logic					ram_ok,
	output logic [4:0]				num_col_addrs,
	output logic [5:0]				num_row_addrs,
	output logic [7:0]				capacity_mbits
);
	import hram_pkg::*;

	// One counter serves both reset phases
	localparam int CNT_MAX	= (RST_LOW_CYCLES > RST_WAIT_CYCLES) ? RST_LOW_CYCLES : RST_WAIT_CYCLES;
	localparam int CNT_W	= $clog2(CNT_MAX + 1);

	boot_state_e		state;
	logic [CNT_W-1:0]	cnt;
	logic				issue_id;	// Start the ID0 read this cycle
	logic				issue_cfg;	// Start the CR0 write this cycle
	id0_u				id;			// Returned ID word
	logic [5:0]			cap_exp;	// log2 of capacity in Mbit

	assign id		= id0_u'(rdata);
	// Word address bits minus 16 for Mbit, both counts are minus-one coded
	assign cap_exp	= 6'(id.fields.cols_m1) + 6'(id.fields.rows_m1) - 6'd14;

	assign issue_id		= (state == RST_WAIT) && (cnt == CNT_W'(RST_WAIT_CYCLES - 1));
	assign issue_cfg	= (state == ID_READ) && burst_done;

	//////////////////////////////
	// Boot burst descriptors

	always_ff @(posedge clk) begin
		if (issue_id) begin
			boot_burst <= '{rd: 1'b1, is_reg: 1'b1, linear: 1'b1,
				upper_addr: ID0_ADDR, lower_addr: 3'h0, len: REG_WORDS};
		end else if (issue_cfg) begin
			boot_burst <= '{rd: 1'b0, is_reg: 1'b1, linear: 1'b1,
				upper_addr: CFG0_ADDR, lower_addr: 3'h0, len: REG_WORDS};
			boot_wdata <= CFG0_VALUE;	// Held until the PHY takes it
		end
	end

	//////////////////////////////
	// Sequencer and status

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state			<= RST_LOW;
			cnt				<= '0;
			ram_rst_n		<= 1'b1;
			boot_start		<= 1'b0;
			status_valid	<= 1'b0;
			ram_ok			<= 1'b0;
			num_col_addrs	<= '0;
			num_row_addrs	<= '0;
			capacity_mbits	<= '0;
		end else begin
			boot_start <= 1'b0;
			case (state)
				RST_LOW: begin
					// Low from the first edge after reset, for RST_LOW_CYCLES
					if (cnt == CNT_W'(RST_LOW_CYCLES)) begin
						ram_rst_n	<= 1'b1;
						cnt			<= '0;
						state		<= RST_WAIT;
					end else begin
						ram_rst_n	<= 1'b0;
						cnt			<= cnt + 1'b1;
					end
				end
				RST_WAIT: begin
					cnt <= cnt + 1'b1;	// Device recovery time
					if (issue_id) begin
						boot_start	<= 1'b1;
						state		<= ID_READ;
					end
				end
				ID_READ: begin
					if (rdata_valid) begin
						ram_ok <= (id.fields.mfr == MFR_CYPRESS);
						if (id.fields.mfr == MFR_CYPRESS) begin
							num_col_addrs	<= 5'(id.fields.cols_m1) + 5'd1;
							num_row_addrs	<= 6'(id.fields.rows_m1) + 6'd1;
							capacity_mbits	<= 8'd1 << cap_exp;
						end
					end
					if (issue_cfg) begin
						boot_start	<= 1'b1;	// CR0 is written even on a bad ID
						state		<= CFG_WRITE;
					end
				end
				CFG_WRITE: begin
					if (burst_done) begin
						status_valid	<= 1'b1;	// Hands the PHY to the host
						state			<= RUN;
					end
				end
				default: state <= RUN;	// RUN holds
			endcase
		end
	end

endmodule

// ==== hdl/hram_host_port.sv ====
`timescale 1ns/1ns

module hram_host_port (
	input  logic					clk,
	input  logic					rst_n,
	input  logic					status_valid,
	input  hram_pkg::burst_req_t	boot_burst,
	input  logic					boot_start,
	input  logic [15:0]				boot_wdata,
	input  logic					bus_en,
	input  logic					bus_rd,
	input  logic [31:0]				bus_addr,
	input  logic [31:0]				bus_wdata,
	input  logic					need_wdata,
	input  logic [15:0]				rdata,
	input  logic					rdata_valid,
	input  logic					burst_done,
	output hram_pkg::burst_req_t	burst,
	output logic					burst_start,
	output logic [15:0]				wdata,
	output logic					bus_need_wdata,
	output logic					bus_rdata_valid,
	output logic [31:0]				bus_rdata,
	output logic					bus_done
);
	import hram_pkg::*;

	burst_req_t		host_burst;
	logic			host_start;
	logic			busy;		// Host burst in flight
	logic			host_rd;
	logic			half;		// 0 = upper half next
	logic			hi_slot;	// bus_wdata is on the bus this cycle
	logic [15:0]	lo_hold;	// Lower write half, sent second
	logic [15:0]	hi_hold;	// Upper read half, arrives first
	logic			accept;
	logic			wr_step;
	logic			rd_step;

	assign accept	= bus_en && status_valid && !busy;	// Dropped while booting or busy
	assign wr_step	= busy && !host_rd && need_wdata;
	assign rd_step	= busy && host_rd && rdata_valid;

	// Boot owns the PHY until status_valid
	assign burst		= status_valid ? host_burst : boot_burst;
	assign burst_start	= status_valid ? host_start : boot_start;
	assign wdata		= !status_valid ? boot_wdata :
		hi_slot ? bus_wdata[31:16] : lo_hold;

	// One host word per two PHY words, answered in the next cycle
	assign bus_need_wdata = wr_step && !half;

	//////////////////////////////
	// Data path

	always_ff @(posedge clk) begin
		if (accept) begin
			host_burst <= '{rd: bus_rd, is_reg: 1'b0, linear: 1'b1,
				upper_addr: bus_addr[31:3], lower_addr: bus_addr[2:0], len: BURST_WORDS};
		end
		if (hi_slot)
			lo_hold <= bus_wdata[15:0];
		if (rd_step && !half)
			hi_hold <= rdata;
		if (rd_step && half)
			bus_rdata <= {hi_hold, rdata};	// Upper half came first
	end

	//////////////////////////////
	// Control

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			host_start		<= 1'b0;
			busy			<= 1'b0;
			host_rd			<= 1'b0;
			half			<= 1'b0;
			hi_slot			<= 1'b0;
			bus_rdata_valid	<= 1'b0;
			bus_done		<= 1'b0;
		end else begin
			host_start		<= accept;
			hi_slot			<= bus_need_wdata;
			bus_rdata_valid	<= rd_step && half;
			bus_done		<= busy && burst_done;	// Boot bursts stay internal
			if (accept) begin
				busy	<= 1'b1;
				host_rd	<= bus_rd;
				half	<= 1'b0;
			end else if (busy && burst_done) begin
				busy	<= 1'b0;
			end
			if (wr_step || rd_step)
				half <= !half;
		end
	end

endmodule

// ==== hdl/hyperram_ctrl.sv ====
`timescale 1ns/1ns

module hyperram_ctrl #(
	parameter int RST_LOW_CYCLES	= 64,	// RAM reset pulse width
	parameter int RST_WAIT_CYCLES	= 128,	// Reset release to first CS
	parameter int WRITE_LATENCY		= 9		// Wait cycles before write data
) (
	input  logic		clk,
	input  logic		rst_n,

	// Host port
	input  logic		bus_en,
	input  logic		bus_rd,
	input  logic [31:0]	bus_addr,
	output logic		bus_need_wdata,
	input  logic [31:0]	bus_wdata,
	output logic		bus_rdata_valid,
	output logic [31:0]	bus_rdata,
	output logic		bus_done,

	// RAM port, SDR side of the pad wrapper
	output logic		ram_rst_n,
	output logic		ram_cs_n,
	output logic		ram_clk_en,
	output logic [15:0]	ram_dq_out,
	output logic		ram_dq_oe,
	input  logic [15:0]	ram_dq_in,
	input  logic		ram_rwds_in,
	output logic		ram_rwds_oe,

	// Boot results
	output logic		status_valid,
	output logic		ram_ok,
	output logic [4:0]	num_col_addrs,
	output logic [5:0]	num_row_addrs,
	output logic [7:0]	capacity_mbits
);
	import hram_pkg::*;

	burst_req_t		boot_burst;		// Boot sequencer request
	burst_req_t		burst;			// Request going to the PHY
	logic			boot_start;
	logic			burst_start;
	logic [15:0]	boot_wdata;
	logic [15:0]	wdata;			// Write word for the PHY
	logic			need_wdata;
	logic [15:0]	rdata;
	logic			rdata_valid;
	logic			burst_done;

	hram_boot #(
		.RST_LOW_CYCLES	(RST_LOW_CYCLES),
		.RST_WAIT_CYCLES(RST_WAIT_CYCLES)
	) u_boot (.*);

	hram_host_port u_host_port (.*);

	hram_phy #(
		.WRITE_LATENCY	(WRITE_LATENCY)
	) u_phy (.*);

endmodule

// ==== hyperram_ctrl.f ====
common/hram_pkg.sv
phy/hram_phy.sv
hdl/hram_boot.sv
hdl/hram_host_port.sv
hdl/hyperram_ctrl.sv
test/hram_model.sv
test/hram_chk.sv
test/tb_hyperram_ctrl.sv

// ==== phy/hram_phy.sv ====
`timescale 1ns/1ns

module hram_phy #(
	parameter int WRITE_LATENCY = 9	// Must be 3 or more for the request lead
) (
	input  logic					clk,
	input  logic					rst_n,
	input  hram_pkg::burst_req_t	burst,
	input  logic					burst_start,
	input  logic [15:0]				wdata,
	output logic					ram_cs_n,
	output logic					ram_clk_en,
	output logic [15:0]				ram_dq_out,
	output logic					ram_dq_oe,
	input  logic [15:0]				ram_dq_in,
	input  logic					ram_rwds_in,
	output logic					ram_rwds_oe,
	output logic					need_wdata,
	output logic [15:0]				rdata,
	output logic					rdata_valid,
	output logic					burst_done
);
	import hram_pkg::*;

	phy_state_e		state;
	ca_word_t		ca_next;	// CA built from the incoming request
	ca_word_t		ca;			// CA of the running burst
	logic [7:0]		lat_cnt;	// Write latency countdown
	logic [7:0]		word_cnt;	// Data words left on the pins
	logic [7:0]		req_cnt;	// Write words not yet requested
	logic			rd_phase;

	assign ca_next = '{rd: burst.rd, is_reg: burst.is_reg, linear: burst.linear,
		upper_addr: burst.upper_addr, rsvd: 13'h0, lower_addr: burst.lower_addr};

	// A read word is any data-phase cycle with RWDS high
	assign rd_phase		= (state == PRE_DATA) || (state == READ_DATA);
	assign rdata		= ram_dq_in;
	assign rdata_valid	= rd_phase && ram_rwds_in;

	always_ff @(posedge clk) begin
		if (state == IDLE && burst_start)
			ca <= ca_next;
	end

	//////////////////////////////
	// Burst FSM

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state		<= IDLE;
			ram_cs_n	<= 1'b1;
			ram_clk_en	<= 1'b0;
			ram_dq_out	<= '0;
			ram_dq_oe	<= 1'b0;
			ram_rwds_oe	<= 1'b0;
			need_wdata	<= 1'b0;
			burst_done	<= 1'b0;
			lat_cnt		<= '0;
			word_cnt	<= '0;
			req_cnt		<= '0;
		end else begin
			need_wdata <= 1'b0;
			burst_done <= 1'b0;
			case (state)
				IDLE: begin
					if (burst_start) begin
						ram_cs_n	<= 1'b0;
						ram_clk_en	<= 1'b1;
						ram_dq_oe	<= 1'b1;
						ram_dq_out	<= ca_next[47:32];	// rd, reg, linear, row MSBs
						word_cnt	<= burst.len;
						state		<= CA0;
					end
				end
				CA0: begin
					ram_dq_out <= ca[31:16];
					// Register write has no wait, ask now for the single word
					if (!ca.rd && ca.is_reg)
						need_wdata <= 1'b1;
					state <= CA1;
				end
				CA1: begin
					ram_dq_out	<= ca[15:0];
					state		<= CA2;
				end
				CA2: begin
					if (ca.rd) begin
						ram_dq_oe	<= 1'b0;	// Turn the bus around
						state		<= RWDS_WAIT;
					end else if (ca.is_reg) begin
						ram_dq_out	<= wdata;
						ram_rwds_oe	<= 1'b1;
						req_cnt		<= '0;
						state		<= WRITE_DATA;
					end else begin
						ram_dq_out	<= '0;
						lat_cnt		<= 8'(WRITE_LATENCY - 1);
						req_cnt		<= word_cnt;
						state		<= WRITE_WAIT;
					end
				end
				WRITE_WAIT: begin
					lat_cnt <= lat_cnt - 1'b1;
					// Requests run two cycles ahead of the pins
					if (lat_cnt <= 8'd2 && req_cnt != '0) begin
						need_wdata	<= 1'b1;
						req_cnt		<= req_cnt - 1'b1;
					end
					if (lat_cnt == '0) begin
						ram_dq_out	<= wdata;
						ram_rwds_oe	<= 1'b1;	// Mask driven low by the pads
						state		<= WRITE_DATA;
					end
				end
				WRITE_DATA: begin
					word_cnt <= word_cnt - 1'b1;
					if (req_cnt != '0) begin
						need_wdata	<= 1'b1;
						req_cnt		<= req_cnt - 1'b1;
					end
					if (word_cnt == 8'd1) begin
						ram_dq_out	<= '0;	// Quiet bus after the last word
						ram_dq_oe	<= 1'b0;
						ram_rwds_oe	<= 1'b0;
						state		<= WRITE_LAST;
					end else begin
						ram_dq_out <= wdata;
					end
				end
				WRITE_LAST: begin
					ram_cs_n	<= 1'b1;
					ram_clk_en	<= 1'b0;
					burst_done	<= 1'b1;
					state		<= IDLE;
				end
				RWDS_WAIT: begin
					// High here means a refresh is still running
					if (!ram_rwds_in)
						state <= PRE_DATA;
				end
				PRE_DATA, READ_DATA: begin
					if (rdata_valid) begin
						word_cnt <= word_cnt - 1'b1;
						if (word_cnt == 8'd1) begin
							ram_cs_n	<= 1'b1;	// Ends on the word count
							ram_clk_en	<= 1'b0;
							burst_done	<= 1'b1;
							state		<= IDLE;
						end else begin
							state <= READ_DATA;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the HyperRAM controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
	--top-module tb_hyperram_ctrl -f hyperram_ctrl.f -o tb_hyperram_ctrl
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_hyperram_ctrl > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
	echo "Simulation FAILED"
	exit 1
fi
echo "Simulation PASSED"
exit 0

// ==== test/hram_chk.sv ====
`timescale 1ns/1ns

module hram_chk (
	input logic	clk,
	input logic	rst_n,
	input logic	bus_en,
	input logic	bus_rd,
	input logic	bus_need_wdata,
	input logic	bus_rdata_valid,
	input logic	ram_cs_n,
	input logic	ram_dq_oe,
	input logic	ram_rwds_oe
);
	logic rd_burst;	// Direction of the latest host request

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rd_burst <= 1'b0;
		else if (bus_en)
			rd_burst <= bus_rd;
	end

	//////////////////////////////
	// Pin and host protocol

	dq_oe_in_cs: assert property (@(posedge clk) disable iff (!rst_n)
		ram_dq_oe |-> !ram_cs_n)
		else $error("ram_dq_oe high while ram_cs_n is high");

	rwds_oe_in_cs: assert property (@(posedge clk) disable iff (!rst_n)
		ram_rwds_oe |-> !ram_cs_n)
		else $error("ram_rwds_oe high while ram_cs_n is high");

	no_wdata_on_read: assert property (@(posedge clk) disable iff (!rst_n)
		bus_need_wdata |-> !rd_burst)
		else $error("bus_need_wdata during a read burst");

	no_rdata_on_write: assert property (@(posedge clk) disable iff (!rst_n)
		bus_rdata_valid |-> rd_burst)
		else $error("bus_rdata_valid during a write burst");

endmodule

bind hyperram_ctrl hram_chk u_chk (.*);

// ==== test/hram_model.sv ====
`timescale 1ns/1ns

module hram_model (
	input  logic				clk,
	input  logic				rst_n,
	input  logic				bad_id,		// Return a foreign manufacturer code
	input  logic				ram_cs_n,
	input  logic				ram_clk_en,	// Device clock runs only while high
	input  logic [15:0]			ram_dq_out,
	input  logic				ram_dq_oe,
	input  logic				ram_rwds_oe,
	output logic [15:0]			ram_dq_in,
	output logic				ram_rwds_in,
	output hram_pkg::ca_word_t	last_ca,	// CA of the latest burst
	output logic [28:0]			reg_wr_addr,
	output logic [15:0]			reg_wr_data,
	output logic [7:0]			reg_wr_cnt
);
	import hram_pkg::*;

	localparam logic [15:0] ID_GOOD	= 16'h0C81;	// 13 rows, 9 columns, mfr 1
	localparam logic [15:0] ID_BAD	= 16'h0C82;

	logic [15:0]	mem [1024];	// Word array on the low address bits
	logic [31:0]	ca_hi;		// First two CA words
	logic [7:0]		cyc;		// Cycles since CS fell
	logic [31:0]	addr;		// Running word address
	ca_word_t		ca_now;
	logic [15:0]	id_word;
	logic [15:0]	dq;			// DQ as the device sees it

	assign dq		= ram_dq_oe ? ram_dq_out : 16'hzzzz;	// Floats when not driven
	assign ca_now	= ca_word_t'({ca_hi, dq});	// Complete at cyc 2
	assign id_word	= bad_id ? ID_BAD : ID_GOOD;

	// One memory word per RWDS-driven cycle
	always_ff @(posedge clk) begin
		if (!ram_cs_n && ram_clk_en && ram_rwds_oe && !last_ca.rd && !last_ca.is_reg)
			mem[addr[9:0]] <= dq;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cyc			<= '0;
			ca_hi		<= '0;
			addr		<= '0;
			last_ca		<= '0;
			reg_wr_addr	<= '0;
			reg_wr_data	<= '0;
			reg_wr_cnt	<= '0;
			ram_dq_in	<= '0;
			ram_rwds_in	<= 1'b0;
		end else if (ram_cs_n) begin
			cyc			<= '0;
			ram_rwds_in	<= 1'b0;	// RWDS idles low between bursts
		end else if (ram_clk_en) begin
			if (cyc != 8'hFF)
				cyc <= cyc + 8'd1;
			case (cyc)
				8'd0: ca_hi[31:16]	<= dq;
				8'd1: ca_hi[15:0]	<= dq;
				8'd2: begin
					last_ca	<= ca_now;
					addr	<= {ca_now.upper_addr, ca_now.lower_addr};
				end
				default: ;
			endcase
			if (ram_rwds_oe && !last_ca.rd) begin
				addr <= addr + 32'd1;
				if (last_ca.is_reg) begin
					reg_wr_addr	<= last_ca.upper_addr;
					reg_wr_data	<= dq;
					reg_wr_cnt	<= reg_wr_cnt + 8'd1;
				end
			end
			// Four RWDS low cycles after the CA and a word every cycle after that
			if (last_ca.rd && cyc >= 8'd6) begin
				ram_rwds_in	<= 1'b1;
				ram_dq_in	<= last_ca.is_reg ? id_word : mem[addr[9:0]];
				addr		<= addr + 32'd1;
			end
		end
	end

endmodule

// ==== test/tb_hyperram_ctrl.sv ====
`timescale 1ns/1ns

module tb_hyperram_ctrl;
	import hram_pkg::*;

	localparam int			CLK_PERIOD		= 100;
	localparam int			BOOT_CYCLES		= 400;	// Reset pulse, wait, ID read, CR0 write
	localparam int			BURST_CYCLES	= 200;
	localparam int			HOST_BURSTS		= 22;	// Write, read, 10 + 10 random
	localparam int			RAM_RST_LOW		= 64;	// ram_rst_n pulse width in cycles
	localparam int			WATCHDOG_NS		=
		(2 * BOOT_CYCLES + HOST_BURSTS * BURST_CYCLES + 20) * CLK_PERIOD;
	localparam logic [31:0]	WR_ADDR			= 32'h0000_012A;	// Upper 0x25, lower 2

	logic			clk;
	logic			rst_n;
	logic			bus_en;
	logic			bus_rd;
	logic [31:0]	bus_addr;
	logic			bus_need_wdata;
	logic [31:0]	bus_wdata;
	logic			bus_rdata_valid;
	logic [31:0]	bus_rdata;
	logic			bus_done;
	logic			ram_rst_n;
	logic			ram_cs_n;
	logic			ram_clk_en;
	logic [15:0]	ram_dq_out;
	logic			ram_dq_oe;
	logic [15:0]	ram_dq_in;
	logic			ram_rwds_in;
	logic			ram_rwds_oe;
	logic			status_valid;
	logic			ram_ok;
	logic [4:0]		num_col_addrs;
	logic [5:0]		num_row_addrs;
	logic [7:0]		capacity_mbits;
	logic			bad_id;
	ca_word_t		model_ca;
	logic [28:0]	reg_wr_addr;
	logic [15:0]	reg_wr_data;
	logic [7:0]		reg_wr_cnt;

	int				mismatch_cnt;
	int				fail_cnt;
	integer			seed;
	logic [31:0]	burst_data [8];		// Host words of the next write
	logic [15:0]	shadow [1024];		// Expected RAM contents
	logic [31:0]	rand_addr [10];

	hyperram_ctrl UUT (.*);

	hram_model ram_model (
		.clk, .rst_n, .bad_id, .ram_cs_n, .ram_clk_en, .ram_dq_out, .ram_dq_oe,
		.ram_rwds_oe, .ram_dq_in, .ram_rwds_in, .last_ca(model_ca),
		.reg_wr_addr, .reg_wr_data, .reg_wr_cnt
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	//////////////////////////////
	// Compare tasks

	task automatic cmp_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			mismatch_cnt++;
			$display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic cmp_ca(input string name, input ca_word_t exp, input ca_word_t act);
		if (act !== exp) begin
			mismatch_cnt++;
			$display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic cmp_status(input logic exp_ok, input logic [4:0] exp_cols,
			input logic [5:0] exp_rows, input logic [7:0] exp_cap);
		if ({ram_ok, num_col_addrs, num_row_addrs, capacity_mbits} !==
				{exp_ok, exp_cols, exp_rows, exp_cap}) begin
			mismatch_cnt++;
			// Fields in the order ok/cols/rows/cap
			$display("Mismatch at %0t: status expected %0d/%0d/%0d/%0d, got %0d/%0d/%0d/%0d",
				$time, exp_ok, exp_cols, exp_rows, exp_cap,
				ram_ok, num_col_addrs, num_row_addrs, capacity_mbits);
		end
	endtask

	//////////////////////////////
	// Bus helpers

	task automatic apply_reset();
		rst_n <= 1'b0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
	endtask

	task automatic wait_status();
		int cyc;
		int low_cyc;
		cyc = 0;
		low_cyc = 0;
		while (!status_valid && cyc < BOOT_CYCLES) begin
			@(posedge clk);
			cyc++;
			if (!ram_rst_n)
				low_cyc++;	// Device reset pulse
		end
		if (!status_valid) begin
			fail_cnt++;
			$display("status_valid did not rise within %0d cycles of reset", BOOT_CYCLES);
		end
		cmp_word("ram_rst_n low cycles", 32'(RAM_RST_LOW), 32'(low_cyc));
	endtask

	task automatic run_write(input logic [31:0] addr);
		int			n;
		int			cyc;
		logic		done;
		logic [9:0]	idx;
		n = 0;
		cyc = 0;
		done = 1'b0;
		@(posedge clk);
		bus_en		<= 1'b1;
		bus_rd		<= 1'b0;
		bus_addr	<= addr;
		@(posedge clk);
		bus_en <= 1'b0;
		while (!done && cyc < BURST_CYCLES) begin
			@(posedge clk);
			cyc++;
			if (bus_need_wdata) begin
				if (n < 8)
					bus_wdata <= burst_data[n];	// Answer in the next cycle
				n++;
			end
			done = bus_done;
		end
		if (!done) begin
			fail_cnt++;
			$display("Write burst to %h did not finish in %0d cycles", addr, BURST_CYCLES);
		end
		cmp_word("bus_need_wdata pulses", 32'd8, 32'(n));
		// Host word i sits at addr + 2i with the upper half first
		for (int i = 0; i < 8; i++) begin
			idx = addr[9:0] + 10'(2 * i);
			shadow[idx] = burst_data[i][31:16];
			shadow[idx + 10'd1] = burst_data[i][15:0];
		end
	endtask

	task automatic run_read(input logic [31:0] addr);
		int			n;
		int			cyc;
		logic		done;
		logic [9:0]	idx;
		n = 0;
		cyc = 0;
		done = 1'b0;
		@(posedge clk);
		bus_en		<= 1'b1;
		bus_rd		<= 1'b1;
		bus_addr	<= addr;
		@(posedge clk);
		bus_en <= 1'b0;
		while (!done && cyc < BURST_CYCLES) begin
			@(posedge clk);
			cyc++;
			if (bus_rdata_valid) begin
				idx = addr[9:0] + 10'(2 * n);
				if (n < 8)
					cmp_word($sformatf("bus_rdata word %0d at %h", n, addr),
						{shadow[idx], shadow[idx + 10'd1]}, bus_rdata);
				n++;
			end
			done = bus_done;
		end
		if (!done) begin
			fail_cnt++;
			$display("Read burst from %h did not finish in %0d cycles", addr, BURST_CYCLES);
		end
		cmp_word("bus_rdata_valid pulses", 32'd8, 32'(n));
	endtask

	//////////////////////////////
	// Directed tests

	task automatic boot_test();
		wait_status();
		cmp_status(1'b1, 5'd9, 6'd13, 8'd64);	// ID 0C81 decodes to a 64 Mbit part
	endtask

	task automatic config_test();
		cmp_word("CR0 write count", 32'd1, 32'(reg_wr_cnt));
		cmp_word("CR0 address", 32'h0000_0100, 32'(reg_wr_addr));
		cmp_word("CR0 value", 32'h0000_BF1F, 32'(reg_wr_data));
	endtask

	task automatic write_test();
		ca_word_t	exp_ca;
		logic [9:0]	idx;
		for (int i = 0; i < 8; i++)
			burst_data[i] = 32'h5A00_A500 + 32'(i) * 32'h0101_0101;
		run_write(WR_ADDR);
		exp_ca = '{rd: 1'b0, is_reg: 1'b0, linear: 1'b1, upper_addr: WR_ADDR[31:3],
			rsvd: 13'h0, lower_addr: WR_ADDR[2:0]};
		cmp_ca("model CA", exp_ca, model_ca);
		for (int i = 0; i < 8; i++) begin
			idx = WR_ADDR[9:0] + 10'(2 * i);
			cmp_word($sformatf("model mem[%h]", idx), {16'h0, burst_data[i][31:16]},
				{16'h0, ram_model.mem[idx]});
			idx = idx + 10'd1;
			cmp_word($sformatf("model mem[%h]", idx), {16'h0, burst_data[i][15:0]},
				{16'h0, ram_model.mem[idx]});
		end
	endtask

	task automatic read_test();
		run_read(WR_ADDR);
	endtask

	task automatic random_test();
		for (int k = 0; k < 10; k++) begin
			rand_addr[k] = $random(seed) & 32'h0000_03F0;	// 16-word aligned within the model
			for (int i = 0; i < 8; i++)
				burst_data[i] = $random(seed);
			run_write(rand_addr[k]);
		end
		for (int k = 0; k < 10; k++)
			run_read(rand_addr[k]);
	endtask

	task automatic bad_id_test();
		bad_id <= 1'b1;
		apply_reset();
		wait_status();
		cmp_status(1'b0, 5'd0, 6'd0, 8'd0);	// Counts stay at their reset value
	endtask

	//////////////////////////////
	// Sequence and watchdog

	initial begin
		mismatch_cnt = 0;
		fail_cnt = 0;
		seed = 32'hb14f;
		bus_en		<= 1'b0;
		bus_rd		<= 1'b0;
		bus_addr	<= '0;
		bus_wdata	<= '0;
		bad_id		<= 1'b0;
		apply_reset();
		boot_test();
		config_test();
		write_test();
		read_test();
		random_test();
		bad_id_test();
		$display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
		if (mismatch_cnt == 0 && fail_cnt == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before the tests finished");
		$display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
		$display("Done: errors found");
		$finish;
	end

endmodule
